/* source/cfg_loader_pkg.sv */
// Configuration loader shared definitions
package cfg_loader_pkg;

    // ------------------------------------------------------------------------
    // Widths and window constants
    // ------------------------------------------------------------------------
    localparam int cfg_data_width    = 32;
    localparam int cfg_offset_width  = 16;
    localparam int cfg_seq_length    = 16;
    localparam int cfg_window_base   = 16;
    localparam int cfg_window_limit  = cfg_window_base + cfg_seq_length;
    localparam int cfg_fifo_depth    = 4;
    localparam int cfg_cmd_width     = 4;
    localparam int cfg_channel_width = 4;
    localparam int cfg_buffer_width  = 8;

    localparam int cfg_fifo_ptr_width   = $clog2(cfg_fifo_depth);
    localparam int cfg_fifo_count_width = $clog2(cfg_fifo_depth + 1);

    // ------------------------------------------------------------------------
    // Response word and its decoded views
    // ------------------------------------------------------------------------
    typedef union packed {
        logic [cfg_data_width-1:0] raw;
        // Position 0, mode bits from bit 0 upwards
        struct packed {
            logic [cfg_data_width-6:0] reserved;
            logic                      mode_counter;
            logic                      mode_buffer;
            logic                      mode_sequence;
            logic                      decrement;
            logic                      increment;
        } flags;
        // Position 4
        struct packed {
            logic                      direction;
            logic [cfg_data_width-2:0] granularity;
        } shift;
        // Position 5, command in the low bits
        struct packed {
            logic [cfg_data_width-cfg_cmd_width-cfg_channel_width-1:0] reserved;
            logic [cfg_channel_width-1:0]                              id_channel;
            logic [cfg_cmd_width-1:0]                                  cmd;
        } route;
    } config_word_u;

    typedef struct packed {
        logic                        valid;
        logic [cfg_offset_width-1:0] offset;
        config_word_u                data;
    } mem_response_t;

    // ------------------------------------------------------------------------
    // Configuration record
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                         increment;
        logic                         decrement;
        logic                         mode_sequence;
        logic                         mode_buffer;
        logic                         mode_counter;
        logic [cfg_data_width-1:0]    index_start;
        logic [cfg_data_width-1:0]    index_end;
        logic [cfg_data_width-1:0]    stride;
        logic [cfg_data_width-2:0]    granularity;
        logic                         direction;
        logic [cfg_cmd_width-1:0]     cmd;
        logic [cfg_channel_width-1:0] id_channel;
        logic [cfg_buffer_width-1:0]  id_buffer;
        logic [cfg_data_width-1:0]    array_size;
        logic [3:0]                   const_mask;
        logic [cfg_data_width-1:0]    const_value;
        logic [15:0]                  ops_mask;
    } config_record_t;

    typedef struct packed {
        logic           valid;
        config_record_t record;
    } config_out_t;

endpackage

/* source/response_window_filter.sv */
// Response window filter
`timescale 1ns/1ps

module response_window_filter (
    input  logic                          ap_clk,
    input  logic                          reset,
    input  cfg_loader_pkg::mem_response_t response_in,
    output cfg_loader_pkg::mem_response_t word_in
);

    import cfg_loader_pkg::*;

    mem_response_t response_q;
    logic          in_window;

    // ------------------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        response_q.offset <= response_in.offset;
        response_q.data   <= response_in.data;
        if (reset) begin
            response_q.valid <= 1'b0;
        end else begin
            response_q.valid <= response_in.valid;
        end
    end

    // ------------------------------------------------------------------------
    // Window test
    // ------------------------------------------------------------------------
    // Upper bound excluded, so exactly one sequence worth of offsets
    assign in_window = (response_q.offset >= cfg_offset_width'(cfg_window_base)) &
                       (response_q.offset <  cfg_offset_width'(cfg_window_limit));

    always_comb begin
        word_in       = response_q;
        word_in.valid = response_q.valid & in_window;
    end

endmodule

/* source/config_word_decoder.sv */
// Configuration word decoder
`timescale 1ns/1ps

module config_word_decoder (
    input  logic                          ap_clk,
    input  logic                          reset,
    input  cfg_loader_pkg::mem_response_t word_in,
    output cfg_loader_pkg::config_out_t   record_push
);

    import cfg_loader_pkg::*;

    logic [cfg_seq_length-1:0] position_q;
    logic                      seq_idle;
    logic                      seq_start;
    logic                      done_q;
    logic                      word_valid_q;
    config_word_u              word_q;
    config_record_t            record_q;

    // ------------------------------------------------------------------------
    // Sequence tracking
    // ------------------------------------------------------------------------
    // Top position means the last word is in, so a new base word may start
    assign seq_idle  = (position_q == '0) | position_q[cfg_seq_length-1];
    assign seq_start = seq_idle & (word_in.offset == cfg_offset_width'(cfg_window_base));

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            position_q   <= '0;
            done_q       <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            done_q       <= position_q[cfg_seq_length-1];
            word_valid_q <= word_in.valid;
            if (word_in.valid) begin
                if (seq_start) begin
                    position_q <= cfg_seq_length'(1);
                end else if (seq_idle) begin
                    position_q <= '0;
                end else begin
                    position_q <= position_q << 1;
                end
            end else if (position_q[cfg_seq_length-1]) begin
                position_q <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Position decode
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        word_q <= word_in.data;
    end

    // Position register and held word line up in the same cycle
    always_ff @(posedge ap_clk) begin
        if (word_valid_q) begin
            case (1'b1)
                position_q[0]: begin
                    record_q.increment     <= word_q.flags.increment;
                    record_q.decrement     <= word_q.flags.decrement;
                    record_q.mode_sequence <= word_q.flags.mode_sequence;
                    record_q.mode_buffer   <= word_q.flags.mode_buffer;
                    record_q.mode_counter  <= word_q.flags.mode_counter;
                end
                position_q[1]: begin
                    record_q.index_start <= word_q.raw;
                end
                position_q[2]: begin
                    record_q.index_end <= word_q.raw;
                end
                position_q[3]: begin
                    record_q.stride <= word_q.raw;
                end
                position_q[4]: begin
                    record_q.granularity <= word_q.shift.granularity;
                    record_q.direction   <= word_q.shift.direction;
                end
                position_q[5]: begin
                    record_q.cmd        <= word_q.route.cmd;
                    record_q.id_channel <= word_q.route.id_channel;
                end
                position_q[6]: begin
                    record_q.id_buffer <= word_q.raw[cfg_buffer_width-1:0];
                end
                position_q[7]: begin
                    record_q.array_size <= word_q.raw;
                end
                position_q[8]: begin
                    record_q.const_mask <= word_q.raw[3:0];
                end
                position_q[9]: begin
                    record_q.const_value <= word_q.raw;
                end
                position_q[10]: begin
                    record_q.ops_mask <= word_q.raw[15:0];
                end
                // Reserved positions 11 to 15
                default: begin
                    record_q <= record_q;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Record output
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        record_push.record <= record_q;
        if (reset) begin
            record_push.valid <= 1'b0;
        end else begin
            record_push.valid <= done_q;
        end
    end

endmodule

/* source/config_fifo.sv */
// Configuration record FIFO
`timescale 1ns/1ps

module config_fifo (
    input  logic                        ap_clk,
    input  logic                        reset,
    input  cfg_loader_pkg::config_out_t record_push,
    input  logic                        rd_en,
    output cfg_loader_pkg::config_out_t config_out,
    output logic                        full,
    output logic                        empty
);

    import cfg_loader_pkg::*;

    config_record_t                  mem [cfg_fifo_depth];
    logic [cfg_fifo_ptr_width-1:0]   wr_ptr;
    logic [cfg_fifo_ptr_width-1:0]   rd_ptr;
    logic [cfg_fifo_count_width-1:0] count;
    logic                            push_en;
    logic                            pop_en;

    function automatic logic [cfg_fifo_ptr_width-1:0] next_ptr(
        input logic [cfg_fifo_ptr_width-1:0] ptr
    );
        if (ptr == cfg_fifo_ptr_width'(cfg_fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == cfg_fifo_count_width'(cfg_fifo_depth));
    assign empty   = (count == '0);
    // Full drops the push, never stalls the decoder
    assign push_en = record_push.valid & ~full;
    assign pop_en  = rd_en & ~empty;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Storage and registered read
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push_en) begin
            mem[wr_ptr] <= record_push.record;
        end
        if (pop_en) begin
            config_out.record <= mem[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            config_out.valid <= 1'b0;
        end else begin
            config_out.valid <= pop_en;
        end
    end

endmodule

/* source/cfg_loader_top.sv */
// Configuration loader top level
`timescale 1ns/1ps

module cfg_loader_top (
    input  logic                          ap_clk,
    input  logic                          reset,
    input  cfg_loader_pkg::mem_response_t response_in,
    input  logic                          config_rd_en,
    output cfg_loader_pkg::config_out_t   config_out,
    output logic                          config_full,
    output logic                          config_empty
);

    import cfg_loader_pkg::*;

    mem_response_t word_in;
    config_out_t   record_push;

    // ------------------------------------------------------------------------
    // Window filter, one register stage
    // ------------------------------------------------------------------------
    response_window_filter u_filter (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .response_in (response_in),
        .word_in     (word_in)
    );

    // ------------------------------------------------------------------------
    // Sequence decoder
    // ------------------------------------------------------------------------
    config_word_decoder u_decoder (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .word_in     (word_in),
        .record_push (record_push)
    );

    // ------------------------------------------------------------------------
    // Output queue
    // ------------------------------------------------------------------------
    config_fifo u_fifo (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .record_push (record_push),
        .rd_en       (config_rd_en),
        .config_out  (config_out),
        .full        (config_full),
        .empty       (config_empty)
    );

endmodule

/* sim/cfg_loader_sva.sv */
// FIFO output protocol checks
`timescale 1ns/1ps

module cfg_loader_sva (
    input logic                        ap_clk,
    input logic                        reset,
    input logic                        rd_en,
    input logic                        full,
    input logic                        empty,
    input cfg_loader_pkg::config_out_t config_out
);

    // Output valid only one cycle after a granted read
    valid_after_pop: assert property (@(posedge ap_clk) disable iff (reset)
        config_out.valid |-> $past(rd_en & ~empty))
        else $error("config_out.valid without a pop in the previous cycle");

    full_and_empty: assert property (@(posedge ap_clk) disable iff (reset)
        !(full && empty))
        else $error("full and empty high together");

    // Still low in the first cycle out of reset
    no_full_after_reset: assert property (@(posedge ap_clk) $past(reset) |-> !full)
        else $error("full high right after reset");

endmodule

bind config_fifo cfg_loader_sva u_sva (
    .ap_clk     (ap_clk),
    .reset      (reset),
    .rd_en      (rd_en),
    .full       (full),
    .empty      (empty),
    .config_out (config_out)
);

/* sim/cfg_loader_tb.sv */
// Configuration loader testbench
`timescale 1ns/1ps

module cfg_loader_tb;

    import cfg_loader_pkg::*;

    // Six tests need about 600 cycles, so ample margin
    localparam int max_cycles = 3000;

    logic           ap_clk;
    logic           reset;
    mem_response_t  response_in;
    logic           config_rd_en;
    config_out_t    config_out;
    logic           config_full;
    logic           config_empty;
    integer         seed = 32'hb622_21f4;
    int             cycles = 0;
    int             test_errors = 0;
    int             pass_count = 0;
    int             fail_count = 0;
    string          test_name = "reset_state";
    logic [31:0]    words [cfg_seq_length];
    config_record_t expected_q [$];

    cfg_loader_top uut (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .response_in  (response_in),
        .config_rd_en (config_rd_en),
        .config_out   (config_out),
        .config_full  (config_full),
        .config_empty (config_empty)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles in test %s", cycles, test_name);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference record model, one field group per position
    // ------------------------------------------------------------------------
    function automatic config_record_t build_record(input logic [31:0] w [cfg_seq_length]);
        config_record_t r;
        r = '0;
        {r.mode_counter, r.mode_buffer, r.mode_sequence, r.decrement, r.increment} = w[0][4:0];
        r.index_start = w[1];
        r.index_end   = w[2];
        r.stride      = w[3];
        r.granularity = w[4][30:0];
        r.direction   = w[4][31];
        r.cmd         = w[5][3:0];
        r.id_channel  = w[5][7:4];
        r.id_buffer   = w[6][7:0];
        r.array_size  = w[7];
        r.const_mask  = w[8][3:0];
        r.const_value = w[9];
        r.ops_mask    = w[10][15:0];
        return r;
    endfunction

    // Both window edges once, otherwise offsets 0 to 15 or 32 to 63
    function automatic logic [15:0] stray_offset(input int k);
        logic [15:0] offset;
        int          r;
        r = $random(seed);
        case (k)
            1:       offset = 16'(cfg_window_base - 1);
            2:       offset = 16'(cfg_window_base + cfg_seq_length);
            default: offset = r[0] ? {12'h000, r[4:1]} : {11'h001, r[5:1]};
        endcase
        return offset;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus and reader
    // ------------------------------------------------------------------------
    task automatic randomize_words(input int first);
        for (int k = first; k < cfg_seq_length; k++) begin
            words[k] = $random(seed);
        end
    endtask

    task automatic send_word(input logic [cfg_offset_width-1:0] offset, input logic [31:0] data);
        @(posedge ap_clk);
        response_in.valid    <= 1'b1;
        response_in.offset   <= offset;
        response_in.data.raw <= data;
    endtask

    task automatic send_sequence(input bit stray);
        for (int k = 0; k < cfg_seq_length; k++) begin
            if (stray) begin
                send_word(stray_offset(k), $random(seed));
            end
            send_word(16'(cfg_window_base + k), words[k]);
        end
        @(posedge ap_clk);
        response_in.valid <= 1'b0;
        expected_q.push_back(build_record(words));
    endtask

    task automatic read_records();
        int             remaining;
        config_record_t exp_record;
        remaining = expected_q.size();
        config_rd_en <= 1'b1;
        while (remaining > 0) begin
            @(posedge ap_clk);
            if (config_out.valid) begin
                exp_record = expected_q.pop_front();
                remaining--;
                assert (config_out.record == exp_record) else begin
                    $display("FAIL %s expected %h actual %h",
                             test_name, exp_record, config_out.record);
                    test_errors++;
                end
            end
        end
        config_rd_en <= 1'b0;
    endtask

    // Settle time covers the filter and decoder latency
    task automatic check_drained();
        repeat (8) @(posedge ap_clk);
        assert (config_empty && !config_out.valid) else begin
            $display("Record left over in the FIFO after test %s", test_name);
            test_errors++;
        end
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %s ok", test_name);
        end else begin
            fail_count++;
            $display("Test %s had %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        reset        = 1'b1;
        response_in  = '0;
        config_rd_en = 1'b0;
        repeat (16) @(posedge ap_clk);
        reset <= 1'b0;
        @(posedge ap_clk);
        assert ({config_out.valid, config_empty, config_full} == 3'b010) else begin
            $display("FAIL %s expected 010 actual %b", test_name,
                     {config_out.valid, config_empty, config_full});
            test_errors++;
        end
        end_test();

        test_name = "single_record";
        randomize_words(0);
        send_sequence(1'b0);
        read_records();
        check_drained();
        end_test();

        test_name = "stray_offsets";
        randomize_words(0);
        send_sequence(1'b1);
        read_records();
        check_drained();
        end_test();

        // In-window words with no base word in front of them
        test_name = "late_start";
        randomize_words(0);
        for (int n = 1; n < 4; n++) begin
            send_word(16'(cfg_window_base + n), $random(seed));
        end
        send_sequence(1'b0);
        read_records();
        check_drained();
        end_test();

        test_name = "reserved_words";
        randomize_words(0);
        send_sequence(1'b0);
        randomize_words(11);
        send_sequence(1'b0);
        read_records();
        check_drained();
        end_test();

        test_name = "fifo_full";
        for (int n = 0; n < 5; n++) begin
            randomize_words(0);
            send_sequence(1'b0);
        end
        wait (config_full);
        repeat (8) @(posedge ap_clk);
        // Fifth record meets a full FIFO and is lost
        void'(expected_q.pop_back());
        assert (config_full) else begin
            $display("FAIL %s expected config_full 1 actual %b", test_name, config_full);
            test_errors++;
        end
        read_records();
        check_drained();
        end_test();

        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* cfg_loader.f */
source/cfg_loader_pkg.sv
source/response_window_filter.sv
source/config_word_decoder.sv
source/config_fifo.sv
source/cfg_loader_top.sv
sim/cfg_loader_sva.sv
sim/cfg_loader_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = cfg_loader_tb
FILELIST  = cfg_loader.f
PASS_MSG  = Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
